// File: src/datapathPkg.sv
package datapathPkg;

	// Register file geometry
	localparam int regCount = 16;
	localparam int regIndexWidth = 4;

	// Instruction opcodes
	// Codes 9 to 15 do nothing
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr  = 4'd3,
		opXor = 4'd4,
		opMov = 4'd5,
		opLsh = 4'd6,
		opRsh = 4'd7,
		opCmp = 4'd8
	} opcodeT;

	// Status flags
	typedef logic [4:0] flagsT;

	localparam int flagC = 4; // Carry or borrow
	localparam int flagL = 3; // Unsigned dest below operand
	localparam int flagF = 2; // Signed overflow
	localparam int flagZ = 1; // Zero result
	localparam int flagN = 0; // Signed dest below operand

	// Setup byte layout, opcode sits in [3:0]
	localparam int setupClrBit = 7;
	localparam int setupImmHighBit = 5;
	localparam int setupImmSelBit = 4;

	// Opcodes that store into the dest register
	function automatic logic writesResult(input opcodeT op);
		return op inside {opAdd, opSub, opAnd, opOr, opXor, opMov, opLsh, opRsh};
	endfunction

	// Cmp touches flags only
	function automatic logic updatesFlags(input opcodeT op);
		return writesResult(op) || (op == opCmp);
	endfunction

endpackage

// File: src/loadDecoder.sv
`timescale 1ns/1ps

module loadDecoder #(
	parameter int dataWidth = 16
) (
	input  logic clk,
	input  logic rstN,
	input  logic [7:0] dataIn,
	input  logic ldReg,
	input  logic ldSetup,
	input  logic ldImm,
	input  logic en,
	output logic [datapathPkg::regIndexWidth-1:0] destIdx,
	output logic [datapathPkg::regIndexWidth-1:0] srcIdx,
	output datapathPkg::opcodeT opcode,
	output logic immSel,
	output logic [dataWidth-1:0] immVal,
	output logic execPulse,
	output logic clrPulse
);
	import datapathPkg::*;

	// Bit positions inside the button vectors
	localparam int btnReg = 0;
	localparam int btnSetup = 1;
	localparam int btnImm = 2;
	localparam int btnEn = 3;

	// Released level of each button
	// Load buttons idle high, enable idles low
	localparam logic [3:0] idleLevel = 4'b0111;

	localparam int padWidth = dataWidth - 8; // Zero fill around the immediate byte

	logic [3:0] btnRaw;
	logic [3:0] syncA;     // First synchronizer flop
	logic [3:0] syncB;     // Second synchronizer flop
	logic [3:0] syncPrev;  // Edge register
	logic [3:0] pressNow;
	logic [3:0] pressOld;
	logic [3:0] pressEdge; // One cycle per press
	logic immHigh;         // Placement of the immediate byte
	logic [7:0] immByte;

	assign btnRaw = {en, ldImm, ldSetup, ldReg};

	// Two-flop synchronizer plus edge register
	// Resets to the idle level so no edge appears out of reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			syncA <= idleLevel;
			syncB <= idleLevel;
			syncPrev <= idleLevel;
		end else begin
			syncA <= btnRaw;
			syncB <= syncA;
			syncPrev <= syncB;
		end
	end

	// Normalize to pressed-high
	assign pressNow = syncB ^ idleLevel;
	assign pressOld = syncPrev ^ idleLevel;
	assign pressEdge = pressNow & ~pressOld;

	// Field latches and request pulses
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			destIdx <= '0;
			srcIdx <= '0;
			opcode <= opAdd;
			immSel <= 1'b0;
			immHigh <= 1'b0;
			immByte <= '0;
			execPulse <= 1'b0;
			clrPulse <= 1'b0;
		end else begin
			execPulse <= pressEdge[btnEn];
			clrPulse <= pressEdge[btnSetup] & dataIn[setupClrBit]; // Same cycle as setup latch
			if (pressEdge[btnReg]) begin
				destIdx <= dataIn[2*regIndexWidth-1 -: regIndexWidth]; // High nibble
				srcIdx <= dataIn[regIndexWidth-1:0];
			end
			if (pressEdge[btnSetup]) begin
				opcode <= opcodeT'(dataIn[3:0]);
				immSel <= dataIn[setupImmSelBit];
				immHigh <= dataIn[setupImmHighBit];
			end
			if (pressEdge[btnImm]) begin
				immByte <= dataIn;
			end
		end
	end

	// Upper half or zero-extended lower half
	assign immVal = immHigh ? {immByte, {padWidth{1'b0}}} : {{padWidth{1'b0}}, immByte};

	// Switches are not synchronized, so they must hold still up to the latch edge
	assert property (@(posedge clk) disable iff (!rstN)
		|pressEdge[btnImm:btnReg] |-> $stable(dataIn))
		else $error("dataIn changed while a load was being latched");

endmodule

// File: src/aluExecute.sv
`timescale 1ns/1ps

module aluExecute #(
	parameter int dataWidth = 16
) (
	input  logic clk,
	input  logic rstN,
	input  logic execPulse,
	input  logic clrPulse,
	input  datapathPkg::opcodeT opcode,
	input  logic immSel,
	input  logic [dataWidth-1:0] immVal,
	input  logic [datapathPkg::regIndexWidth-1:0] destIdx,
	input  logic [dataWidth-1:0] destData,
	input  logic [dataWidth-1:0] srcData,
	output logic wrEn,
	output logic [datapathPkg::regIndexWidth-1:0] wrIdx,
	output logic [dataWidth-1:0] wrData,
	output datapathPkg::flagsT flags
);
	import datapathPkg::*;

	localparam int msb = dataWidth - 1;

	logic [dataWidth-1:0] opB;      // Second operand
	logic [3:0] shiftAmt;
	logic [dataWidth:0] sumWide;    // Carry out on top
	logic [dataWidth:0] diffWide;   // Borrow out on top
	logic [dataWidth-1:0] result;
	logic addOverflow;
	logic subOverflow;
	logic destBelow;        // Unsigned compare
	logic destBelowSigned;
	flagsT flagsNext;

	assign opB = immSel ? immVal : srcData;
	assign shiftAmt = opB[3:0]; // Only low bits count for shifts

	assign sumWide = {1'b0, destData} + {1'b0, opB};
	assign diffWide = {1'b0, destData} - {1'b0, opB};

	// Operands agree in sign but the sum does not
	assign addOverflow = (destData[msb] == opB[msb]) && (sumWide[msb] != destData[msb]);
	// Operands differ in sign and the difference flips
	assign subOverflow = (destData[msb] != opB[msb]) && (diffWide[msb] != destData[msb]);

	assign destBelow = destData < opB;
	assign destBelowSigned = $signed(destData) < $signed(opB);

	// Result select
	always_comb begin
		case (opcode)
			opAdd: result = sumWide[msb:0];
			opSub: result = diffWide[msb:0];
			opCmp: result = diffWide[msb:0]; // Feeds flags only
			opAnd: result = destData & opB;
			opOr:  result = destData | opB;
			opXor: result = destData ^ opB;
			opMov: result = opB;
			opLsh: result = destData << shiftAmt;
			opRsh: result = destData >> shiftAmt; // Logical
			default: result = '0;
		endcase
	end

	// Next flag vector
	// Logic and shifts keep C, L and F
	always_comb begin
		flagsNext = flags;
		flagsNext[flagZ] = (result == '0);
		flagsNext[flagN] = result[msb]; // Sign bit outside arithmetic
		case (opcode)
			opAdd: begin
				flagsNext[flagC] = sumWide[dataWidth];
				flagsNext[flagL] = destBelow;
				flagsNext[flagF] = addOverflow;
				flagsNext[flagN] = destBelowSigned;
			end
			opSub, opCmp: begin
				flagsNext[flagC] = diffWide[dataWidth]; // Borrow
				flagsNext[flagL] = destBelow;
				flagsNext[flagF] = subOverflow;
				flagsNext[flagN] = destBelowSigned;
			end
			default: ;
		endcase
	end

	// Write strobe and flag register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrEn <= 1'b0;
			flags <= '0;
		end else begin
			wrEn <= execPulse && writesResult(opcode);
			if (clrPulse) begin
				flags <= '0;
			end else if (execPulse && updatesFlags(opcode)) begin
				flags <= flagsNext; // No-op codes leave flags alone
			end
		end
	end

	// Writeback payload
	always_ff @(posedge clk) begin
		if (execPulse) begin
			wrIdx <= destIdx;
			wrData <= result;
		end
	end

	// Cmp and codes 9 to 15 never reach the register file
	assert property (@(posedge clk) disable iff (!rstN)
		execPulse && (opcode >= opCmp) |=> !wrEn)
		else $error("wrEn after Cmp or no-op");

	// A write issued with a clear would land after the wipe
	assert property (@(posedge clk) disable iff (!rstN) !(execPulse && clrPulse))
		else $error("execPulse and clrPulse in the same cycle");

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile #(
	parameter int dataWidth = 16
) (
	input  logic clk,
	input  logic rstN,
	input  logic clrPulse,
	input  logic wrEn,
	input  logic [datapathPkg::regIndexWidth-1:0] wrIdx,
	input  logic [dataWidth-1:0] wrData,
	input  logic [datapathPkg::regIndexWidth-1:0] destIdx,
	input  logic [datapathPkg::regIndexWidth-1:0] srcIdx,
	output logic [dataWidth-1:0] destData,
	output logic [dataWidth-1:0] srcData
);
	import datapathPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// Clear wins over a same-cycle write
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (clrPulse) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; // Setup bit 7 wipe
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Read ports, no latency
	assign destData = regs[destIdx]; // Also the displayed value
	assign srcData = regs[srcIdx];

endmodule

// File: src/hexDisplay.sv
`timescale 1ns/1ps

module hexDisplay #(
	parameter int dataWidth = 16
) (
	input  logic [dataWidth-1:0] value,
	output logic [dataWidth/4-1:0][6:0] segOut // Top index is the leftmost digit
);

	localparam int digitCount = dataWidth / 4;

	// Nibble to active-low gfedcba
	function automatic logic [6:0] segPattern(input logic [3:0] nibble);
		logic [6:0] lit; // Segments on, active high
		case (nibble)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1100111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100; // Lower-case b
			4'hC: lit = 7'b1011000; // Lower-case c
			4'hD: lit = 7'b1011110; // Lower-case d
			4'hE: lit = 7'b1111001;
			4'hF: lit = 7'b1110001;
			default: lit = 7'b0000000;
		endcase
		return ~lit; // Board segments sink current
	endfunction

	// One decoder per nibble
	for (genvar d = 0; d < digitCount; d++) begin : gDigit
		assign segOut[d] = segPattern(value[4*d +: 4]);
	end

endmodule

// File: src/regAluTop.sv
`timescale 1ns/1ps

module regAluTop #(
	parameter int dataWidth = 16
) (
	input  logic clk,
	input  logic rstN,
	input  logic [7:0] dataIn,  // Switch bank
	input  logic ldReg,         // Active low
	input  logic ldSetup,       // Active low
	input  logic ldImm,         // Active low
	input  logic en,            // Run one instruction
	output logic [dataWidth-1:0] destOut,
	output datapathPkg::flagsT flags,
	output logic [dataWidth/4-1:0][6:0] segOut
);
	import datapathPkg::*;

	// Decoder outputs
	logic [regIndexWidth-1:0] destIdx;
	logic [regIndexWidth-1:0] srcIdx;
	opcodeT opcode;
	logic immSel;
	logic [dataWidth-1:0] immVal;
	logic execPulse;
	logic clrPulse;

	// Register file read and write paths
	logic [dataWidth-1:0] srcData;
	logic wrEn;
	logic [regIndexWidth-1:0] wrIdx;
	logic [dataWidth-1:0] wrData;

	loadDecoder #(.dataWidth(dataWidth)) uDecode (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.ldReg(ldReg),
		.ldSetup(ldSetup),
		.ldImm(ldImm),
		.en(en),
		.destIdx(destIdx),
		.srcIdx(srcIdx),
		.opcode(opcode),
		.immSel(immSel),
		.immVal(immVal),
		.execPulse(execPulse),
		.clrPulse(clrPulse)
	);

	aluExecute #(.dataWidth(dataWidth)) uExecute (
		.clk(clk),
		.rstN(rstN),
		.execPulse(execPulse),
		.clrPulse(clrPulse),
		.opcode(opcode),
		.immSel(immSel),
		.immVal(immVal),
		.destIdx(destIdx),
		.destData(destOut),
		.srcData(srcData),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.flags(flags)
	);

	// Dest read port doubles as the board output
	regFile #(.dataWidth(dataWidth)) uRegs (
		.clk(clk),
		.rstN(rstN),
		.clrPulse(clrPulse),
		.wrEn(wrEn),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.destIdx(destIdx),
		.srcIdx(srcIdx),
		.destData(destOut),
		.srcData(srcData)
	);

	hexDisplay #(.dataWidth(dataWidth)) uDisplay (
		.value(destOut),
		.segOut(segOut)
	);

endmodule

// File: verification/regAluTb.sv
`timescale 1ns/1ps

module regAluTb;
	import datapathPkg::*;

	localparam int dataWidth = 16;
	localparam int btnReg = 0;
	localparam int btnSetup = 1;
	localparam int btnImm = 2;
	localparam int btnEn = 3;
	localparam int pressCycles = 11; // Start edge, two held, eight settling
	// Reset/clear, placement, arithmetic, logic, no-op, display
	localparam int totalPresses = 65 + 80 + 280 + 180 + 28 + 128;
	localparam int timeoutCycles = 2 * (5 + totalPresses * (pressCycles + 1));

	// Active-low gfedcba, digits 0 to F
	localparam logic [6:0] segTable [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h27, 7'h21, 7'h06, 7'h0E
	};

	logic clk;
	logic rstN;
	logic [7:0] dataIn;
	logic ldReg;
	logic ldSetup;
	logic ldImm;
	logic en;
	logic [dataWidth-1:0] destOut;
	flagsT flags;
	logic [dataWidth/4-1:0][6:0] segOut;

	logic [15:0] regModel [16]; // Expected register contents
	flagsT flagModel;
	int errorCount;
	int cycleCount;

	regAluTop #(.dataWidth(dataWidth)) UUT (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.ldReg(ldReg),
		.ldSetup(ldSetup),
		.ldImm(ldImm),
		.en(en),
		.destOut(destOut),
		.flags(flags),
		.segOut(segOut)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Press, hold two cycles, release, let the pipeline settle
	task automatic pressButton(input int btn, input logic [7:0] value);
		@(posedge clk);
		dataIn <= value; // Stays put until the next press
		case (btn)
			btnReg: ldReg <= 1'b0;
			btnSetup: ldSetup <= 1'b0;
			btnImm: ldImm <= 1'b0;
			default: en <= 1'b1;
		endcase
		repeat (2) @(posedge clk);
		ldReg <= 1'b1;
		ldSetup <= 1'b1;
		ldImm <= 1'b1;
		en <= 1'b0;
		repeat (8) @(posedge clk); // Writeback lands within five edges
	endtask

	task automatic checkData(input string name, input logic [dataWidth-1:0] actual,
			input logic [dataWidth-1:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkFlags(input flagsT actual, input flagsT expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: flags expected %b got %b", $time, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkSeg(input int digit, input logic [6:0] actual, input logic [6:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: segOut[%0d] expected %b got %b",
				$time, digit, expected, actual);
			errorCount++;
		end
	endtask

	// Reference model of the opcode and flag rules
	task automatic applyModel(input logic [3:0] op, input logic [3:0] dest, input logic [15:0] b);
		logic [15:0] a;
		logic [15:0] r;
		int ua;
		int ub;
		int sa;
		int sb;
		int wide;
		a = regModel[dest];
		ua = {16'h0, a};
		ub = {16'h0, b};
		sa = {{16{a[15]}}, a};
		sb = {{16{b[15]}}, b};
		wide = 0;
		if (op <= 4'd8) begin // Codes above 8 change nothing
			case (op)
				opAdd: begin
					r = a + b;
					flagModel[flagC] = (ua + ub) > 65535; // Carry out
					wide = sa + sb;
				end
				opSub, opCmp: begin
					r = a - b;
					flagModel[flagC] = ua < ub; // Borrow
					wide = sa - sb;
				end
				opAnd: r = a & b;
				opOr: r = a | b;
				opXor: r = a ^ b;
				opMov: r = b;
				opLsh: r = a << b[3:0];
				opRsh: r = a >> b[3:0];
				default: r = '0;
			endcase
			flagModel[flagZ] = (r == 16'h0);
			if (op == opAdd || op == opSub || op == opCmp) begin
				flagModel[flagL] = ua < ub;
				flagModel[flagF] = (wide > 32767) || (wide < -32768); // Outside 16-bit signed
				flagModel[flagN] = sa < sb;
			end else begin
				flagModel[flagN] = r[15];
			end
			if (op != opCmp) regModel[dest] = r;
		end
	endtask

	// One full instruction, then check dest and flags
	task automatic execOp(input logic [3:0] op, input logic [3:0] dest, input logic [3:0] src,
			input logic immSel, input logic immHigh, input logic [7:0] imm);
		logic [7:0] setup;
		logic [15:0] b;
		setup = {4'h0, op};
		setup[setupImmSelBit] = immSel;
		setup[setupImmHighBit] = immHigh;
		b = immHigh ? {imm, 8'h00} : {8'h00, imm};
		if (!immSel) b = regModel[src];
		pressButton(btnReg, {dest, src});
		pressButton(btnSetup, setup);
		pressButton(btnImm, imm);
		pressButton(btnEn, 8'h00);
		applyModel(op, dest, b);
		@(negedge clk);
		checkData("destOut", destOut, regModel[dest]);
		checkFlags(flags, flagModel);
	endtask

	// Full word via upper byte then OR of lower byte
	task automatic setReg(input logic [3:0] idx, input logic [15:0] value);
		execOp(opMov, idx, idx, 1'b1, 1'b1, value[15:8]);
		execOp(opOr, idx, idx, 1'b1, 1'b0, value[7:0]);
	endtask

	task automatic readReg(input logic [3:0] idx);
		pressButton(btnReg, {idx, 4'h0});
		@(negedge clk);
		checkData("destOut", destOut, regModel[idx]);
	endtask

	task automatic arithCase(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
		logic [31:0] rnd;
		logic [3:0] dest;
		logic [3:0] src;
		rnd = $urandom;
		dest = rnd[3:0];
		src = dest + 4'd1 + (rnd[7:4] % 4'd15); // Never equal to dest
		setReg(dest, a);
		setReg(src, b);
		execOp(op, dest, src, 1'b0, 1'b0, 8'h00);
		if (op == opCmp) checkData("destOut after Cmp", destOut, a);
	endtask

	task automatic resetAndClear();
		logic [31:0] rnd;
		@(negedge clk);
		checkFlags(flags, '0);
		for (int i = 0; i < 16; i++) readReg(4'(i));
		for (int i = 0; i < 4; i++) begin
			rnd = $urandom;
			setReg(4'(4 * i + 1), rnd[15:0] | 16'h8101); // Nonzero and negative so the wipe shows
		end
		pressButton(btnSetup, 8'h80);
		for (int i = 0; i < 16; i++) regModel[i] = '0;
		flagModel = '0;
		@(negedge clk);
		checkFlags(flags, flagModel);
		for (int i = 0; i < 16; i++) readReg(4'(i));
	endtask

	task automatic immPlacement();
		logic [31:0] rnd;
		for (int i = 0; i < 20; i++) begin
			rnd = $urandom;
			execOp(opMov, rnd[3:0], rnd[7:4], 1'b1, rnd[8], rnd[23:16]);
		end
	endtask

	task automatic arithFlags();
		logic [31:0] rnd;
		logic [3:0] ops [3];
		ops[0] = opAdd;
		ops[1] = opSub;
		ops[2] = opCmp;
		arithCase(opAdd, 16'hFFFF, 16'h0001); // Carry, zero result
		arithCase(opAdd, 16'h7FFF, 16'h0001); // Signed overflow
		arithCase(opSub, 16'h8000, 16'h0001);
		arithCase(opSub, 16'h0001, 16'h0002); // Borrow
		arithCase(opCmp, 16'h1234, 16'h1234); // Equal
		for (int i = 0; i < 9; i++) begin
			rnd = $urandom;
			arithCase(ops[i % 3], rnd[31:16], rnd[15:0]);
		end
	endtask

	task automatic logicShift();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [3:0] dest;
		logic [3:0] ops [5];
		ops[0] = opAnd;
		ops[1] = opOr;
		ops[2] = opXor;
		ops[3] = opLsh;
		ops[4] = opRsh;
		arithCase(opSub, 16'h7FFF, 16'hFFFF); // C, L and F all set
		for (int i = 0; i < 5; i++) begin
			rnd = $urandom;
			rnd2 = $urandom;
			dest = rnd[3:0];
			setReg(dest, rnd[31:16]);
			setReg(dest ^ 4'h8, rnd2[31:16]);
			execOp(ops[i], dest, dest ^ 4'h8, 1'b0, 1'b0, 8'h00);
			setReg(dest, rnd2[31:16]);
			// Shift amount comes from low bits, so keep the byte low there
			execOp(ops[i], dest, dest, 1'b1, (i < 3) ? rnd2[0] : 1'b0, rnd2[15:8]);
		end
	endtask

	task automatic noOpCodes();
		logic [31:0] rnd;
		for (int op = 9; op < 16; op++) begin
			rnd = $urandom;
			execOp(4'(op), rnd[3:0], rnd[7:4], rnd[8], 1'b0, rnd[23:16]);
		end
	endtask

	task automatic displayDigits();
		logic [15:0] value;
		for (int d = 0; d < 16; d++) begin
			value = {4'(d + 3), 4'(d + 2), 4'(d + 1), 4'(d)}; // Each digit visits each slot
			setReg(4'(d), value);
			@(negedge clk);
			for (int p = 0; p < 4; p++) checkSeg(p, segOut[p], segTable[value[4*p +: 4]]);
		end
	endtask

	initial begin
		rstN = 1'b0;
		dataIn = 8'h00;
		ldReg = 1'b1;
		ldSetup = 1'b1;
		ldImm = 1'b1;
		en = 1'b0;
		errorCount = 0;
		flagModel = '0;
		for (int i = 0; i < 16; i++) regModel[i] = '0;
		void'($urandom(32'h704d));
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		resetAndClear();
		immPlacement();
		arithFlags();
		logicShift();
		noOpCodes();
		displayDigits();
		$display("Errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: tests did not finish within %0d cycles", timeoutCycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: flist.f
src/datapathPkg.sv
src/loadDecoder.sv
src/aluExecute.sv
src/regFile.sv
src/hexDisplay.sv
src/regAluTop.sv
verification/regAluTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f flist.f \
	--top-module regAluTb \
	-o regAluSim

./obj_dir/regAluSim > sim.log
cat sim.log

if grep -q "Done: no errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
